// File: verif/memGolden.txt
# kind: F fetch, L load, S store, A load racing the next F line, R random stalls from here
# columns: kind addr(hex) len data(hex) expected(hex)
F 00000010 4 00000000 49484b4a
F 00000021 4 00000000 7e79787b
L 00000030 1 00000000 0000006a
L 00000031 2 00000000 0000686b
L 00000040 4 00000000 19181b1a
L 0000008f 1 00000000 000000d5
L 000000c6 2 00000000 00009d9c
S 00000050 1 deadbeef 00000000
L 00000050 4 00000000 09080bef
S 00000061 2 1234a5c3 00000000
L 00000060 4 00000000 39a5c33a
S 00000070 4 cafef00d 00000000
L 00000070 4 00000000 cafef00d
L 0000006f 4 00000000 fef00d35
A 00000080 4 00000000 d9d8dbda
F 00000090 4 00000000 c9c8cbca
R 00000000 0 00000000 00000000
F 00000010 4 00000000 49484b4a
L 00000052 2 00000000 00000908
S 000000a0 4 89abcdef 00000000
L 000000a0 4 00000000 89abcdef
S 000000a2 1 00000077 00000000
L 000000a0 4 00000000 8977cdef
L 000000a1 2 00000000 000077cd
S 000000b3 2 0000beef 00000000
L 000000b2 4 00000000 efbeefe8
A 000000f0 1 00000000 000000aa
F 000000fc 4 00000000 a5a4a7a6
F 00000071 4 00000000 2ecafef0
L 000000ff 1 00000000 000000a5

// File: vlog.f
common/memPkg.sv
memctrl/memCtrlFsm.sv
memctrl/memReqLatch.sv
memctrl/byteAssembler.sv
memctrl/storeSlicer.sv
verilog/memSubsystem.sv
verif/tbClock.sv
verif/byteRam.sv
verif/memSubsystemTb.sv

// File: verif/memSubsystemTb.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystemTb;

    wire clk;
    wire rst;

    logic                       rdy;
    logic                       ioFull;
    logic                       fetchEn;
    logic [memPkg::ADDR_W-1:0]  fetchAddr;
    logic                       dcEn;
    memPkg::memReq_t            dcReq;
    wire                        fetchDone;
    wire [memPkg::WORD_W-1:0]   fetchInst;
    wire                        dcDone;
    wire [memPkg::WORD_W-1:0]   dcData;
    wire [memPkg::BYTE_W-1:0]   memData;
    wire memPkg::memPort_t      mem;
    wire                        rangeErr;

    int          fd;
    bit          stallMode = 1'b0;
    integer      seed = 32'h8666;
    logic [31:0] stallBits;
    int          dcOps = 0;
    int          fetchOps = 0;
    int          dcPulses = 0;
    int          fetchPulses = 0;

    tbClock i_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    memSubsystem i_dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_rdy       (rdy),
        .i_ioFull    (ioFull),
        .i_fetchEn   (fetchEn),
        .i_fetchAddr (fetchAddr),
        .o_fetchDone (fetchDone),
        .o_fetchInst (fetchInst),
        .i_dcEn      (dcEn),
        .i_dcReq     (dcReq),
        .o_dcDone    (dcDone),
        .o_dcData    (dcData),
        .i_memData   (memData),
        .o_mem       (mem)
    );

    byteRam i_ram (
        .i_clk      (clk),
        .i_mem      (mem),
        .o_data     (memData),
        .o_rangeErr (rangeErr)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (expVal === actVal) else begin
            abortRun($sformatf("error %s: expected %h, actual %h", name, expVal, actVal));
        end
    endtask

    // skips comment lines, ok stays low at end of file
    task automatic readOp(output logic [7:0] kind, output logic [31:0] addr,
                          output logic [31:0] len, output logic [31:0] data,
                          output logic [31:0] expVal, output bit ok);
        logic [63:0]    token;
        logic [959:0]   rest;
        int             code;
        bit             found;
        found = 1'b0;
        ok = 1'b0;
        kind = 8'h00;
        while (!found) begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) begin
                found = 1'b1;
            end else if (token == "#") begin
                code = $fgets(rest, fd);
            end else begin
                kind = token[7:0];
                code = $fscanf(fd, "%h %h %h %h", addr, len, data, expVal);
                if (code != 4) begin
                    abortRun("golden file line has fewer than five columns");
                end
                ok = 1'b1;
                found = 1'b1;
            end
        end
    endtask

    // cycles counts from the cycle the request is first visible
    task automatic waitForDone(input string name, input bit wantFetch,
                               output int cycles, output logic [31:0] result);
        bit seen;
        seen = 1'b0;
        cycles = 0;
        result = '0;
        while (!seen) begin
            @(negedge clk);
            if (wantFetch ? fetchDone : dcDone) begin
                seen = 1'b1;
                result = wantFetch ? fetchInst : dcData;
            end else begin
                assert (!(wantFetch ? dcDone : fetchDone)) else begin
                    abortRun($sformatf("%s: the other requester finished first", name));
                end
                cycles++;
                if (cycles > 50) begin
                    abortRun($sformatf("timeout waiting for done in %s", name));
                end
            end
        end
    endtask

    task automatic confirmSinglePulse(input string name, input bit wantFetch);
        @(negedge clk);
        assert (!(wantFetch ? fetchDone : dcDone)) else begin
            abortRun($sformatf("%s: done stayed high for more than one cycle", name));
        end
    endtask

    task automatic runFetch(input string name, input logic [31:0] addr,
                            input logic [31:0] expVal);
        int          cycles;
        logic [31:0] got;
        @(posedge clk);
        fetchEn <= 1'b1;
        fetchAddr <= addr;
        waitForDone(name, 1'b1, cycles, got);
        @(posedge clk);
        fetchEn <= 1'b0;
        confirmSinglePulse(name, 1'b1);
        checkValue(name, expVal, got);
        if (!stallMode) begin
            checkValue({name, " latency"}, 32'd5, 32'(cycles));
        end
        fetchOps++;
    endtask

    task automatic runData(input string name, input memPkg::memReq_t req,
                           input logic [31:0] expVal);
        int          cycles;
        int          expCycles;
        logic [31:0] got;
        @(posedge clk);
        dcEn <= 1'b1;
        dcReq <= req;
        waitForDone(name, 1'b0, cycles, got);
        @(posedge clk);
        dcEn <= 1'b0;
        confirmSinglePulse(name, 1'b0);
        if (!req.isStore) begin
            checkValue(name, expVal, got);
        end
        // writes finish with the last byte, reads one cycle later
        expCycles = req.isStore ? int'(req.len) : int'(req.len) + 1;
        if (!stallMode) begin
            checkValue({name, " latency"}, 32'(expCycles), 32'(cycles));
        end
        dcOps++;
    endtask

    // both enables rise together, data cache must win
    task automatic runPair(input string dcName, input memPkg::memReq_t req,
                           input logic [31:0] dcExp, input string fetchName,
                           input logic [31:0] addr, input logic [31:0] fetchExp);
        int          cycles;
        logic [31:0] got;
        @(posedge clk);
        dcEn <= 1'b1;
        dcReq <= req;
        fetchEn <= 1'b1;
        fetchAddr <= addr;
        waitForDone(dcName, 1'b0, cycles, got);
        @(posedge clk);
        dcEn <= 1'b0;
        confirmSinglePulse(dcName, 1'b0);
        checkValue(dcName, dcExp, got);
        if (!stallMode) begin
            checkValue({dcName, " latency"}, 32'(int'(req.len) + 1), 32'(cycles));
        end
        waitForDone(fetchName, 1'b1, cycles, got);
        @(posedge clk);
        fetchEn <= 1'b0;
        confirmSinglePulse(fetchName, 1'b1);
        checkValue(fetchName, fetchExp, got);
        dcOps++;
        fetchOps++;
    endtask

    always @(posedge clk) begin
        if (stallMode) begin
            stallBits = $random(seed);
            ioFull <= (stallBits[1:0] == 2'b00);
            rdy <= (stallBits[3:2] != 2'b00);
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (dcDone) begin
                dcPulses++;
            end
            if (fetchDone) begin
                fetchPulses++;
            end
            assert ((rdy && !ioFull) || !(mem.en || mem.write || fetchDone || dcDone)) else begin
                abortRun("memory enable, write or a done pulse was high in a stalled cycle");
            end
            assert (fetchDone || (fetchInst == '0)) else begin
                abortRun("fetch result was not zero outside its done cycle");
            end
            assert (dcDone || (dcData == '0)) else begin
                abortRun("load result was not zero outside its done cycle");
            end
            assert (!rangeErr) else begin
                abortRun("memory access outside the modeled 256 bytes");
            end
        end
    end

    initial begin
        logic [7:0]      kind;
        logic [7:0]      nextKind;
        logic [31:0]     addr;
        logic [31:0]     len;
        logic [31:0]     data;
        logic [31:0]     expVal;
        logic [31:0]     pairAddr;
        logic [31:0]     pairExp;
        memPkg::memReq_t req;
        bit              more;
        int              opIndex;
        int              waited;
        string           name;
        rdy = 1'b1;
        ioFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dcEn = 1'b0;
        dcReq = '0;
        opIndex = 0;
        fd = $fopen("verif/memGolden.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open verif/memGolden.txt");
        end
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                abortRun("reset was never released");
            end
        end while (rst);
        @(negedge clk);
        assert (!mem.en && !mem.write && !fetchDone && !dcDone) else begin
            abortRun("controller was not idle after reset");
        end
        more = 1'b1;
        while (more) begin
            readOp(kind, addr, len, data, expVal, more);
            if (more) begin
                opIndex++;
                name = $sformatf("op%0d_%c", opIndex, kind);
                req.addr = addr;
                req.data = data;
                req.len = len[2:0];
                req.isStore = (kind == "S");
                if (kind == "F") begin
                    runFetch(name, addr, expVal);
                end else if ((kind == "L") || (kind == "S")) begin
                    runData(name, req, expVal);
                end else if (kind == "A") begin
                    readOp(nextKind, pairAddr, len, data, pairExp, more);
                    assert (more && (nextKind == "F")) else begin
                        abortRun("golden file has an A line without an F line after it");
                    end
                    opIndex++;
                    runPair(name, req, expVal, $sformatf("op%0d_F", opIndex),
                            pairAddr, pairExp);
                end else if (kind == "R") begin
                    stallMode = 1'b1;
                end else begin
                    abortRun($sformatf("golden file has an unknown kind %c", kind));
                end
            end
        end
        $fclose(fd);
        assert (opIndex > 0) else begin
            abortRun("golden file held no operations");
        end
        checkValue("data cache done pulses", 32'(dcOps), 32'(dcPulses));
        checkValue("fetch done pulses", 32'(fetchOps), 32'(fetchPulses));
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/byteRam.sv
`timescale 1ns/1ns
`default_nettype none

module byteRam (
    input  wire                          i_clk,
    input  wire memPkg::memPort_t        i_mem,
    output logic [memPkg::BYTE_W-1:0]    o_data,
    output logic                         o_rangeErr
);

    logic [memPkg::BYTE_W-1:0] mem [0:255];

    // every byte holds its address xor 5a until written
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h5A;
        end
        o_data = '0;
    end

    // only 256 bytes are modeled
    assign o_rangeErr = i_mem.en && (i_mem.addr[memPkg::ADDR_W-1:8] != '0);

    // synchronous read, one cycle latency, held while en is low
    always @(posedge i_clk) begin
        if (i_mem.en) begin
            if (i_mem.write) begin
                mem[i_mem.addr[7:0]] <= i_mem.data;
            end
            o_data <= mem[i_mem.addr[7:0]];
        end
    end

endmodule

`default_nettype wire

// File: verif/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic o_clk,
    output logic o_rst
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // reset seen by two rising edges
    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/memSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystem (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire                          i_rdy,
    input  wire                          i_ioFull,
    input  wire                          i_fetchEn,
    input  wire [memPkg::ADDR_W-1:0]     i_fetchAddr,
    output logic                         o_fetchDone,
    output logic [memPkg::WORD_W-1:0]    o_fetchInst,
    input  wire                          i_dcEn,
    input  wire memPkg::memReq_t         i_dcReq,
    output logic                         o_dcDone,
    output logic [memPkg::WORD_W-1:0]    o_dcData,
    input  wire [memPkg::BYTE_W-1:0]     i_memData,
    output memPkg::memPort_t             o_mem
);

    wire                        latch;
    wire                        grantData;
    wire                        advance;
    wire memPkg::owner_t        owner;
    wire memPkg::stage_t        stage;
    wire                        memEn;
    wire                        memWrite;
    wire memPkg::memReq_t       req;
    wire [memPkg::ADDR_W-1:0]   memAddr;
    wire [memPkg::BYTE_W-1:0]   memByte;

    memCtrlFsm i_fsm (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rdy       (i_rdy),
        .i_ioFull    (i_ioFull),
        .i_fetchEn   (i_fetchEn),
        .i_dcEn      (i_dcEn),
        .i_dcIsStore (i_dcReq.isStore),
        .i_len       (req.len),
        .o_latch     (latch),
        .o_grantData (grantData),
        .o_advance   (advance),
        .o_owner     (owner),
        .o_stage     (stage),
        .o_memEn     (memEn),
        .o_memWrite  (memWrite),
        .o_fetchDone (o_fetchDone),
        .o_dcDone    (o_dcDone)
    );

    memReqLatch i_reqLatch (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_latch     (latch),
        .i_grantData (grantData),
        .i_dcReq     (i_dcReq),
        .i_fetchAddr (i_fetchAddr),
        .o_req       (req)
    );

    byteAssembler i_assembler (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_advance   (advance),
        .i_owner     (owner),
        .i_stage     (stage),
        .i_len       (req.len),
        .i_memData   (i_memData),
        .o_fetchInst (o_fetchInst),
        .o_dcData    (o_dcData)
    );

    storeSlicer i_slicer (
        .i_req     (req),
        .i_stage   (stage),
        .o_memAddr (memAddr),
        .o_memByte (memByte)
    );

    assign o_mem = '{en: memEn, write: memWrite, addr: memAddr, data: memByte};

endmodule

`default_nettype wire

// File: memctrl/storeSlicer.sv
`timescale 1ns/1ns
`default_nettype none

module storeSlicer (
    input  wire memPkg::memReq_t         i_req,
    input  wire memPkg::stage_t          i_stage,
    output logic [memPkg::ADDR_W-1:0]    o_memAddr,
    output logic [memPkg::BYTE_W-1:0]    o_memByte
);

    // one byte per stage, walking up from the base address
    assign o_memAddr = i_req.addr + memPkg::ADDR_W'(i_stage);

    // little endian, stage 0 is the low byte
    always_comb begin
        case (i_stage[1:0])
            2'd0: o_memByte = i_req.data[7:0];
            2'd1: o_memByte = i_req.data[15:8];
            2'd2: o_memByte = i_req.data[23:16];
            default: o_memByte = i_req.data[31:24];
        endcase
    end

endmodule

`default_nettype wire

// File: memctrl/byteAssembler.sv
`timescale 1ns/1ns
`default_nettype none

module byteAssembler (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire                          i_advance,
    input  wire memPkg::owner_t          i_owner,
    input  wire memPkg::stage_t          i_stage,
    input  wire memPkg::len_t            i_len,
    input  wire [memPkg::BYTE_W-1:0]     i_memData,
    output logic [memPkg::WORD_W-1:0]    o_fetchInst,
    output logic [memPkg::WORD_W-1:0]    o_dcData
);

    logic [memPkg::PART_W-1:0] partial;
    logic [memPkg::WORD_W-1:0] word;

    logic isRead;
    logic readDone;

    assign isRead = (i_owner == memPkg::FETCH) || (i_owner == memPkg::LOAD);
    assign readDone = i_advance && isRead && (i_stage == i_len);

    // byte k arrives while stage is k+1
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            partial <= '0;
        end else if (i_advance && isRead && (i_stage != i_len)) begin
            case (i_stage)
                3'd1: partial[7:0] <= i_memData;
                3'd2: partial[15:8] <= i_memData;
                3'd3: partial[23:16] <= i_memData;
                default: partial <= partial;
            endcase
        end
    end

    // last byte merged live, lanes above zero filled
    always_comb begin
        case (i_len)
            memPkg::LEN_BYTE: word = {24'd0, i_memData};
            memPkg::LEN_HALF: word = {16'd0, i_memData, partial[7:0]};
            default: word = {i_memData, partial};
        endcase
    end

    assign o_fetchInst = (readDone && (i_owner == memPkg::FETCH)) ? word : '0;
    assign o_dcData = (readDone && (i_owner == memPkg::LOAD)) ? word : '0;

endmodule

`default_nettype wire

// File: memctrl/memReqLatch.sv
`timescale 1ns/1ns
`default_nettype none

module memReqLatch (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire                          i_latch,
    input  wire                          i_grantData,
    input  wire memPkg::memReq_t         i_dcReq,
    input  wire [memPkg::ADDR_W-1:0]     i_fetchAddr,
    output memPkg::memReq_t              o_req
);

    memPkg::memReq_t fetchReq;
    memPkg::memReq_t req;

    // an instruction fetch is always a four byte read
    always_comb begin
        fetchReq.addr = i_fetchAddr;
        fetchReq.data = '0;
        fetchReq.len = memPkg::LEN_WORD;
        fetchReq.isStore = 1'b0;
    end

    // held for the whole transfer so requesters are free after done
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            req <= '0;
        end else if (i_latch) begin
            if (i_grantData) begin
                req <= i_dcReq;
            end else begin
                req <= fetchReq;
            end
        end
    end

    assign o_req = req;

endmodule

`default_nettype wire

// File: memctrl/memCtrlFsm.sv
`timescale 1ns/1ns
`default_nettype none

module memCtrlFsm (
    input  wire               i_clk,
    input  wire               i_rst,
    input  wire               i_rdy,
    input  wire               i_ioFull,
    input  wire               i_fetchEn,
    input  wire               i_dcEn,
    input  wire               i_dcIsStore,
    input  wire memPkg::len_t i_len,
    output logic              o_latch,
    output logic              o_grantData,
    output logic              o_advance,
    output memPkg::owner_t    o_owner,
    output memPkg::stage_t    o_stage,
    output logic              o_memEn,
    output logic              o_memWrite,
    output logic              o_fetchDone,
    output logic              o_dcDone
);

    memPkg::owner_t owner;
    memPkg::stage_t stage;
    memPkg::stage_t nextStage;
    memPkg::stage_t lastWrite;

    logic advance;
    logic isRead;
    logic readDone;
    logic writeDone;

    // frozen whenever the cpu pauses or the io buffer is full
    assign advance = i_rdy && !i_ioFull;

    assign isRead = (owner == memPkg::FETCH) || (owner == memPkg::LOAD);

    assign nextStage = memPkg::stage_t'(stage + 3'd1);
    assign lastWrite = memPkg::stage_t'(i_len - 3'd1);

    // reads finish one stage after the last address, when the final byte is back
    assign readDone = isRead && (stage == i_len);

    // writes finish on the cycle of the last byte write
    assign writeDone = (owner == memPkg::STORE) && (stage == lastWrite);

    // data cache has priority over fetch
    assign o_grantData = i_dcEn;
    assign o_latch = advance && (owner == memPkg::IDLE) && (i_fetchEn || i_dcEn);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner <= memPkg::IDLE;
            stage <= '0;
        end else if (advance) begin
            case (owner)
                memPkg::IDLE: begin
                    stage <= '0;
                    if (i_dcEn) begin
                        owner <= i_dcIsStore ? memPkg::STORE : memPkg::LOAD;
                    end else if (i_fetchEn) begin
                        owner <= memPkg::FETCH;
                    end
                end
                memPkg::FETCH,
                memPkg::LOAD: begin
                    if (readDone) begin
                        owner <= memPkg::IDLE;
                        stage <= '0;
                    end else begin
                        stage <= nextStage;
                    end
                end
                memPkg::STORE: begin
                    if (writeDone) begin
                        owner <= memPkg::IDLE;
                        stage <= '0;
                    end else begin
                        stage <= nextStage;
                    end
                end
                default: begin
                    owner <= memPkg::IDLE;
                    stage <= '0;
                end
            endcase
        end
    end

    // en stays low while frozen so the RAM keeps its read register
    assign o_memEn = advance && ((isRead && (stage != i_len)) || (owner == memPkg::STORE));
    assign o_memWrite = advance && (owner == memPkg::STORE);

    assign o_fetchDone = advance && readDone && (owner == memPkg::FETCH);
    assign o_dcDone = advance && ((readDone && (owner == memPkg::LOAD)) || writeDone);

    assign o_advance = advance;
    assign o_owner = owner;
    assign o_stage = stage;

endmodule

`default_nettype wire

// File: common/memPkg.sv
`default_nettype none

package memPkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;

    // lanes held in the partial word; the top lane comes live from the RAM
    localparam int PART_W = WORD_W - BYTE_W;

    // transfer length in bytes
    typedef logic [2:0] len_t;

    localparam len_t LEN_BYTE = 3'd1;
    localparam len_t LEN_HALF = 3'd2;
    localparam len_t LEN_WORD = 3'd4;

    // byte stage within a transfer, 0 to 4
    typedef logic [2:0] stage_t;

    // who owns the memory port right now
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        LOAD,
        STORE
    } owner_t;

    // data cache request, held steady until done
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
        len_t              len;
        logic              isStore;
    } memReq_t;

    // byte-wide RAM port
    typedef struct packed {
        logic              en;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] data;
    } memPort_t;

endpackage

`default_nettype wire
